//--- verilog.f
hdl/adder_cfg_pkg.sv
hdl/prefix_cell_pkg.sv
hdl/pg_precompute.sv
hdl/prefix_level.sv
hdl/sum_postcompute.sv
hdl/prefix_adder_pipe.sv
testbench/prefix_adder_props.sv
testbench/prefix_adder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the prefix adder testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f verilog.f --top-module prefix_adder_tb \
	-o prefix_adder_sim || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/prefix_adder_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q 'All tests passed!' && echo "Simulation PASSED" || {
	echo "Simulation FAILED"
	exit 1
}

//--- testbench/prefix_adder_golden.txt
# a b cin sum cout, hex, 16-bit operands
# sum and cout are the low 16 bits and the carry of a + b + cin
0000 0000 0 0000 0
0001 0001 0 0002 0
1234 4321 0 5555 0
ffff 0001 0 0000 1
8000 8000 0 0000 1
00ff 0f01 0 1000 0
abcd 1234 0 be01 0
7fff 7fff 0 fffe 0
ffff ffff 0 fffe 1
5555 aaaa 0 ffff 0
c350 3cb0 0 0000 1
ffff 0000 1 0000 1
0000 0000 1 0001 0
5555 aaaa 1 0000 1
7fff 0000 1 8000 0
1234 4321 1 5556 0
fffe 0001 1 0000 1
8000 7fff 1 0000 1
0f0f f0f0 1 0000 1
9abc def0 1 79ad 1
0001 fffe 0 ffff 0
00ff ff00 1 0000 1

//--- testbench/prefix_adder_tb.sv
// Testbench for the pipelined prefix adder with golden vectors, result queue and checks
`timescale 1ns/1ns

module prefix_adder_tb;

	import adder_cfg_pkg::*;

	localparam int WIDTH = ADDER_WIDTH;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 10;
	// Precompute, log2(WIDTH) tree levels, fix-up level, postcompute
	localparam int LATENCY = $clog2(WIDTH) + 3;
	localparam int DRAIN_LIMIT = 4 * LATENCY;
	localparam int SEED = 28;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	operand_t a;
	operand_t b;
	logic     cin;
	logic     out_valid;
	operand_t sum;
	logic     cout;

	// Vectors from the golden file
	operand_t vec_a[$];
	operand_t vec_b[$];
	logic     vec_cin[$];
	operand_t vec_sum[$];
	logic     vec_cout[$];

	// Results still in flight in issue order
	operand_t exp_sum_q[$];
	logic     exp_cout_q[$];
	string    name_q[$];

	int setup_errors = 0;
	int result_errors = 0;

	prefix_adder_pipe #(.WIDTH(WIDTH)) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

	bind prefix_adder_pipe prefix_adder_props #(.WIDTH(WIDTH)) u_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Reference sum with one extra bit for the carry
	function automatic logic [WIDTH:0] ref_add(input operand_t x, input operand_t y,
			input logic c);
		return {1'b0, x} + {1'b0, y} + {{WIDTH{1'b0}}, c};
	endfunction

	task automatic check_sum(input string name, input operand_t expected,
			input operand_t actual, inout int err_count);
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_cout(input string name, input logic expected,
			input logic actual, inout int err_count);
		if (actual !== expected) begin
			err_count++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int rc;
		int line_no;
		string line;
		operand_t va;
		operand_t vb;
		operand_t vs;
		logic vc;
		logic vco;
		logic [WIDTH:0] ref_val;
		fd = $fopen("testbench/prefix_adder_golden.txt", "r");
		if (fd == 0) begin
			setup_errors++;
			$display("ERROR: cannot open testbench/prefix_adder_golden.txt");
			return;
		end
		line_no = 0;
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			line_no++;
			// Comment lines do not scan as five fields
			if (rc > 0) begin
				rc = $sscanf(line, "%h %h %h %h %h", va, vb, vc, vs, vco);
				if (rc == 5) begin
					ref_val = ref_add(va, vb, vc);
					check_sum($sformatf("golden line %0d sum", line_no), ref_val[WIDTH-1:0],
						vs, setup_errors);
					check_cout($sformatf("golden line %0d cout", line_no), ref_val[WIDTH],
						vco, setup_errors);
					vec_a.push_back(va);
					vec_b.push_back(vb);
					vec_cin.push_back(vc);
					vec_sum.push_back(ref_val[WIDTH-1:0]);
					vec_cout.push_back(ref_val[WIDTH]);
				end
			end
		end
		$fclose(fd);
		if (vec_a.size() == 0) begin
			setup_errors++;
			$display("ERROR: golden file holds no vectors");
		end
	endtask

	task automatic issue_vector(input int idx, input int pass_no);
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b1;
		a = vec_a[idx];
		b = vec_b[idx];
		cin = vec_cin[idx];
		exp_sum_q.push_back(vec_sum[idx]);
		exp_cout_q.push_back(vec_cout[idx]);
		name_q.push_back($sformatf("pass %0d vector %0d", pass_no, idx));
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		cin = 1'b0;
	endtask

	task automatic collect_result();
		string name;
		operand_t exp_sum;
		logic exp_cout;
		if (exp_sum_q.size() == 0) begin
			result_errors++;
			$display("ERROR: out_valid high with no result outstanding at %0t", $time);
			return;
		end
		name = name_q.pop_front();
		exp_sum = exp_sum_q.pop_front();
		exp_cout = exp_cout_q.pop_front();
		check_sum({name, " sum"}, exp_sum, sum, result_errors);
		check_cout({name, " cout"}, exp_cout, cout, result_errors);
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst_n && out_valid) begin
			result_errors++;
			$display("ERROR: out_valid high during reset at %0t", $time);
		end else if (out_valid) begin
			collect_result();
		end
	end

	initial begin
		int gap;
		int wait_cycles;
		int assert_fails;
		void'($urandom(SEED));
		rst_n = 1'b0;
		// Items offered early in reset must never reach the output
		in_valid = 1'b1;
		a = '1;
		b = '1;
		cin = 1'b1;
		load_vectors();
		repeat (RESET_CYCLES - LATENCY - 1) @(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		cin = 1'b0;
		repeat (LATENCY + 1) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		// One vector per cycle fills the pipe
		for (int i = 0; i < vec_a.size(); i++) begin
			issue_vector(i, 1);
		end
		idle_cycle();
		// Same vectors again with random idle gaps
		for (int i = 0; i < vec_a.size(); i++) begin
			gap = $urandom_range(3, 0);
			repeat (gap) idle_cycle();
			issue_vector(i, 2);
		end
		idle_cycle();
		wait_cycles = 0;
		while (exp_sum_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_sum_q.size() != 0) begin
			setup_errors++;
			$display("ERROR: %0d results never came out of the adder", exp_sum_q.size());
		end
		// Late strobes on a quiet pipe are caught by the monitor
		repeat (LATENCY + 2) @(posedge clk);
		assert_fails = uut.u_props.fail_count;
		$display("Errors: %0d setup, %0d result, %0d assertion",
			setup_errors, result_errors, assert_fails);
		if (setup_errors == 0 && result_errors == 0 && assert_fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- testbench/prefix_adder_props.sv
// Concurrent assertions on the adder valid pipeline and on result integrity
`timescale 1ns/1ns

module prefix_adder_props #(
	parameter int WIDTH = adder_cfg_pkg::ADDER_WIDTH
) (
	input logic             clk,
	input logic             rst_n,
	input logic             in_valid,
	input logic             out_valid,
	input logic [WIDTH-1:0] sum,
	input logic             cout
);

	import adder_cfg_pkg::*;

	localparam int LATENCY = pipe_latency(WIDTH);

	int fail_count = 0;

	// Strobe leaves the pipe exactly LATENCY edges after it entered
	valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, LATENCY))
	else begin
		fail_count++;
		$error("out_valid does not follow in_valid delayed by %0d cycles", LATENCY);
	end

	result_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({sum, cout}))
	else begin
		fail_count++;
		$error("sum or cout has unknown bits while out_valid is high");
	end

	// No strobe may escape while reset is held
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid is high while rst_n is low");
	end

endmodule

//--- hdl/prefix_adder_pipe.sv
// Pipelined prefix adder top level chaining precompute, prefix levels and postcompute
`timescale 1ns/1ns

module prefix_adder_pipe #(
	parameter int WIDTH = adder_cfg_pkg::ADDER_WIDTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             cin,
	output logic             out_valid,
	output logic [WIDTH-1:0] sum,
	output logic             cout
);

	import adder_cfg_pkg::*;

	localparam int NUM_LEVELS = prefix_levels(WIDTH);

	logic           pre_valid;
	logic [WIDTH:0] pre_p;
	logic [WIDTH:0] pre_g;

	logic           lvl_valid [NUM_LEVELS];
	logic [WIDTH:0] lvl_p     [NUM_LEVELS];
	logic [WIDTH:0] lvl_g     [NUM_LEVELS];
	logic [WIDTH:0] lvl_xp    [NUM_LEVELS];

	pg_precompute #(.WIDTH(WIDTH)) u_pre (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.pre_valid (pre_valid),
		.pre_p     (pre_p),
		.pre_g     (pre_g)
	);

	for (genvar k = 0; k < NUM_LEVELS; k++) begin : g_level
		if (k == 0) begin : g_first
			// Bitwise propagate doubles as the xp copy at the tree input
			prefix_level #(.WIDTH(WIDTH), .LEVEL(k)) u_level (
				.clk       (clk),
				.rst_n     (rst_n),
				.in_valid  (pre_valid),
				.p_in      (pre_p),
				.g_in      (pre_g),
				.xp_in     (pre_p),
				.out_valid (lvl_valid[k]),
				.p_out     (lvl_p[k]),
				.g_out     (lvl_g[k]),
				.xp_out    (lvl_xp[k])
			);
		end else begin : g_next
			prefix_level #(.WIDTH(WIDTH), .LEVEL(k)) u_level (
				.clk       (clk),
				.rst_n     (rst_n),
				.in_valid  (lvl_valid[k-1]),
				.p_in      (lvl_p[k-1]),
				.g_in      (lvl_g[k-1]),
				.xp_in     (lvl_xp[k-1]),
				.out_valid (lvl_valid[k]),
				.p_out     (lvl_p[k]),
				.g_out     (lvl_g[k]),
				.xp_out    (lvl_xp[k])
			);
		end
	end

	// Last level holds the carries, its group propagates are no longer needed
	sum_postcompute #(.WIDTH(WIDTH)) u_post (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (lvl_valid[NUM_LEVELS-1]),
		.carry_g   (lvl_g[NUM_LEVELS-1]),
		.xp_in     (lvl_xp[NUM_LEVELS-1]),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

endmodule

//--- hdl/sum_postcompute.sv
// Postcompute stage registering sum and carry-out from the prefix carries
`timescale 1ns/1ns

module sum_postcompute #(
	parameter int WIDTH = adder_cfg_pkg::ADDER_WIDTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [WIDTH:0]   carry_g,
	input  logic [WIDTH:0]   xp_in,
	output logic             out_valid,
	output logic [WIDTH-1:0] sum,
	output logic             cout
);

	import prefix_cell_pkg::*;

	logic [WIDTH-1:0] sum_nxt;
	logic             cout_nxt;

	// carry_g[k] is the group generate from 0 to k, i.e. the carry into position k+1
	assign sum_nxt = xp_in[WIDTH:1] ^ carry_g[WIDTH-1:0];

	// Top position was never touched by the tree, one more grey cell
	assign cout_nxt = grey_g(carry_g[WIDTH], xp_in[WIDTH], carry_g[WIDTH-1]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			sum <= '0;
			cout <= 1'b0;
		end else begin
			out_valid <= in_valid;
			sum <= sum_nxt;
			cout <= cout_nxt;
		end
	end

endmodule

//--- hdl/prefix_level.sv
// One registered level of the sparse prefix tree, or the final grey fix-up level
`timescale 1ns/1ns

module prefix_level #(
	parameter int WIDTH = adder_cfg_pkg::ADDER_WIDTH,
	parameter int LEVEL = 0
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  logic [WIDTH:0] p_in,
	input  logic [WIDTH:0] g_in,
	input  logic [WIDTH:0] xp_in,
	output logic           out_valid,
	output logic [WIDTH:0] p_out,
	output logic [WIDTH:0] g_out,
	output logic [WIDTH:0] xp_out
);

	import prefix_cell_pkg::*;

	localparam int SPAN = level_span(LEVEL);
	// Tree levels run 0 .. log2(WIDTH)-1, the next one fills the even positions
	localparam bit FIXUP = (LEVEL == $clog2(WIDTH));

	logic [WIDTH:0] p_nxt;
	logic [WIDTH:0] g_nxt;

	// Tree covers positions 0 .. WIDTH-1, the top position is left for cout
	for (genvar i = 0; i <= WIDTH; i++) begin : g_pos
		if (FIXUP && (i >= 2) && (i < WIDTH) && (i % 2 == 0)) begin : g_fix
			// Own bit joined with the complete group just below
			assign g_nxt[i] = grey_g(g_in[i], p_in[i], g_in[i-1]);
			assign p_nxt[i] = p_in[i];
		end else if (!FIXUP && (i < WIDTH) && (i % 2 == 1) && (i >= SPAN) &&
				(i < 2 * SPAN)) begin : g_grey
			// Lower group already reaches bit 0
			assign g_nxt[i] = grey_g(g_in[i], p_in[i], g_in[i-SPAN]);
			assign p_nxt[i] = p_in[i];
		end else if (!FIXUP && (i < WIDTH) && (i % 2 == 1) &&
				(i >= 2 * SPAN)) begin : g_black
			assign g_nxt[i] = black_g(g_in[i], p_in[i], g_in[i-SPAN]);
			assign p_nxt[i] = black_p(p_in[i], p_in[i-SPAN]);
		end else begin : g_pass
			assign g_nxt[i] = g_in[i];
			assign p_nxt[i] = p_in[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			p_out <= '0;
			g_out <= '0;
			xp_out <= '0;
		end else begin
			out_valid <= in_valid;
			p_out <= p_nxt;
			g_out <= g_nxt;
			// Bitwise propagate, kept for the sum
			xp_out <= xp_in;
		end
	end

endmodule

//--- hdl/pg_precompute.sv
// Precompute stage registering propagate and generate vectors with the valid strobe
`timescale 1ns/1ns

module pg_precompute #(
	parameter int WIDTH = adder_cfg_pkg::ADDER_WIDTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             cin,
	output logic             pre_valid,
	output logic [WIDTH:0]   pre_p,
	output logic [WIDTH:0]   pre_g
);

	logic [WIDTH:0] p_nxt;
	logic [WIDTH:0] g_nxt;

	// Position 0 stands for the carry-in: it generates cin and never propagates
	assign p_nxt = {a ^ b, 1'b0};
	assign g_nxt = {a & b, cin};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_valid <= 1'b0;
			pre_p <= '0;
			pre_g <= '0;
		end else begin
			pre_valid <= in_valid;
			pre_p <= p_nxt;
			pre_g <= g_nxt;
		end
	end

endmodule

//--- hdl/prefix_cell_pkg.sv
// Black and grey prefix cell operators and the span of each tree level
package prefix_cell_pkg;

	// Black cell, group generate half
	function automatic logic black_g(input logic g_hi, input logic p_hi, input logic g_lo);
		return g_hi | (p_hi & g_lo);
	endfunction

	// Black cell, group propagate half
	function automatic logic black_p(input logic p_hi, input logic p_lo);
		return p_hi & p_lo;
	endfunction

	// Grey cell, only the generate is needed once the group reaches bit 0
	function automatic logic grey_g(input logic g_hi, input logic p_hi, input logic g_lo);
		return g_hi | (p_hi & g_lo);
	endfunction

	// Distance to the lower group at tree level k
	// The level after the last tree level is the fix-up level
	function automatic int level_span(input int k);
		return 1 << k;
	endfunction

endpackage

//--- hdl/adder_cfg_pkg.sv
// Adder width, pipeline depth constants and the operand type
package adder_cfg_pkg;

	// Default operand width of the adder
	localparam int ADDER_WIDTH = 16;

	// Register stages around the prefix tree
	localparam int PRE_STAGES = 1;
	localparam int POST_STAGES = 1;

	typedef logic [ADDER_WIDTH-1:0] operand_t;

	// Tree levels of span 1, 2, 4, ... plus the grey fix-up level
	function automatic int prefix_levels(input int width);
		return $clog2(width) + 1;
	endfunction

	// Cycles from in_valid to out_valid
	function automatic int pipe_latency(input int width);
		return PRE_STAGES + prefix_levels(width) + POST_STAGES;
	endfunction

endpackage
